//--- vram_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VRAM package with geometry, start-up contents and the request bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package vram_pkg;

    localparam int VRAM_AW    = 8;                   // 256 words
    localparam int VRAM_WORDS = 1 << VRAM_AW;
    localparam int VRAM_DW    = 16;                  // attribute byte + character byte

    localparam logic [VRAM_DW-1:0] CLEAR_DATA = 16'h1F20;   // white on blue, space

    localparam int CHARS_WIDE = 16;                  // text columns per row

    // banner sits on row 1, two columns in
    localparam logic [VRAM_AW-1:0] BANNER_ADDR = VRAM_AW'(1 * CHARS_WIDE + 2);
    localparam int BANNER_LEN = 7;
    localparam int BANNER_IW  = $clog2(BANNER_LEN);  // banner index width

    localparam logic [VRAM_DW-1:0] BANNER [BANNER_LEN] = '{
        {8'h1E, "V"},
        {8'h1C, "R"},
        {8'h1B, "A"},
        {8'h12, "M"},
        {8'h17, " "},
        {8'h1A, "O"},
        {8'h1A, "K"}
    };

    // one VRAM access, either owner
    typedef struct packed {
        logic               sel;     // access requested
        logic               wr;      // 1 = write, 0 = read
        logic [VRAM_AW-1:0] addr;
        logic [VRAM_DW-1:0] wdata;
    } vram_req_t;

endpackage

//--- xvid_regs_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host register map and register write bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package xvid_regs_pkg;

    localparam int REG_DW = 16;     // host register width

    typedef enum logic [3:0] {
        RD_ADDR,        // 0 start a VRAM read
        WR_ADDR,        // 1 VRAM write address
        DATA,           // 2 write word, auto increment
        DATA_2,         // 3 second half of a 32-bit write
        VID_MODE,       // 4 bit 0 toggles video enable
        BLIT_CTRL,      // 5 unused
        RD_INC,         // 6 unused
        WR_INC,         // 7 unused
        RD_MOD,         // 8 unused
        WR_MOD,         // 9 unused
        WIDTH,          // a unused
        COUNT,          // b unused
        AUX_RD_ADDR,    // c unused
        AUX_WR_ADDR,    // d unused
        AUX_DATA,       // e unused
        AUX_CTRL        // f unused
    } xvid_reg_t;

    typedef struct packed {
        logic               strobe;  // one cycle write pulse
        xvid_reg_t          num;
        logic [REG_DW-1:0]  data;
    } reg_wr_t;

endpackage

//--- video_scanner.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video scanner, owns the slot toggle and streams VRAM out on video slots
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module video_scanner (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            video_ena_i,
    output logic                            blit_cycle_o,   // 0 = video slot, 1 = blit slot
    output vram_pkg::vram_req_t             vid_req_o,
    input  logic [vram_pkg::VRAM_DW-1:0]    rd_data_i,
    output logic [vram_pkg::VRAM_DW-1:0]    video_word_o,
    output logic                            video_valid_o,
    output logic                            video_sof_o
);

    logic                           blit_cycle;
    logic                           vid_sel;        // high on video slots once running
    logic [vram_pkg::VRAM_AW-1:0]   scan_addr;
    logic                           pend;           // rd_data_i holds our word this cycle
    logic                           pend_sof;       // ...and it came from address 0

    always_ff @(posedge clk) begin
        if (reset_i) begin
            blit_cycle <= 1'b0;
            vid_sel    <= 1'b0;
            scan_addr  <= '0;
            pend       <= 1'b0;
            pend_sof   <= 1'b0;
        end else begin
            blit_cycle <= ~blit_cycle;
            // next cycle is a video slot when this one is a blit slot
            vid_sel    <= blit_cycle;
            pend       <= vid_sel;
            pend_sof   <= vid_sel && (scan_addr == '0);
            if (vid_sel) begin
                scan_addr <= scan_addr + 1'b1;      // wraps at VRAM_WORDS
            end
        end
    end

    assign blit_cycle_o = blit_cycle;

    // scanner only ever reads
    always_comb begin
        vid_req_o.sel   = vid_sel;
        vid_req_o.wr    = 1'b0;
        vid_req_o.addr  = scan_addr;
        vid_req_o.wdata = '0;
    end

    // Shared read port, so the word is only ours when pend says so.
    // The address keeps running while video is off; only the qualifiers drop.
    assign video_word_o  = rd_data_i;
    assign video_valid_o = pend & video_ena_i;
    assign video_sof_o   = pend_sof & video_ena_i;

endmodule

//--- blitter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Blitter, clears VRAM and draws the banner at start-up,
// then turns host register writes into VRAM accesses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module blitter (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            blit_cycle_i,   // 1 = VRAM is ours this clock
    input  xvid_regs_pkg::reg_wr_t          reg_wr_i,
    output logic                            reg_busy_o,
    output logic [vram_pkg::VRAM_DW-1:0]    reg_rd_data_o,
    output logic                            video_ena_o,
    output vram_pkg::vram_req_t             blit_req_o,
    input  logic [vram_pkg::VRAM_DW-1:0]    rd_data_i
);

    typedef enum logic [1:0] {
        IDLE,
        INIT,
        CLEAR,
        BANNER
    } blit_state_t;

    blit_state_t                        state;

    logic                               req_sel;
    logic                               req_wr;
    logic [vram_pkg::VRAM_DW-1:0]       wdata_q;
    logic [vram_pkg::VRAM_AW-1:0]       rd_addr;
    logic [vram_pkg::VRAM_AW-1:0]       wr_addr;
    logic [vram_pkg::VRAM_AW-1:0]       clr_count;      // clear words still to issue
    logic [vram_pkg::BANNER_IW-1:0]     ban_idx;
    logic [vram_pkg::BANNER_IW-1:0]     ban_next;
    logic                               rd_pend;        // read data arrives this cycle
    logic [vram_pkg::VRAM_DW-1:0]       rd_data_q;
    logic                               acc_done;
    logic                               take;

    assign acc_done = req_sel & blit_cycle_i;           // request served on this edge
    assign take     = reg_wr_i.strobe & ~reg_busy_o;    // strobes while busy are dropped
    assign ban_next = ban_idx + 1'b1;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= INIT;
            req_sel     <= 1'b0;
            req_wr      <= 1'b0;
            rd_pend     <= 1'b0;
            video_ena_o <= 1'b0;
        end else begin
            rd_pend <= 1'b0;
            if (rd_pend) begin
                rd_data_q <= rd_data_i;                 // held until next read completes
            end

            if (acc_done) begin
                if (req_wr) begin
                    wr_addr <= wr_addr + 1'b1;          // auto increment after each write
                end else begin
                    rd_pend <= 1'b1;
                end
            end

            // a held request blocks everything until its blit slot
            if (acc_done || !req_sel) begin
                req_sel <= 1'b0;
                req_wr  <= 1'b0;

                case (state)
                    IDLE: begin
                        if (take) begin
                            case (reg_wr_i.num)
                                xvid_regs_pkg::RD_ADDR: begin
                                    rd_addr <= reg_wr_i.data[vram_pkg::VRAM_AW-1:0];
                                    req_sel <= 1'b1;
                                end
                                xvid_regs_pkg::WR_ADDR: begin
                                    wr_addr <= reg_wr_i.data[vram_pkg::VRAM_AW-1:0];
                                end
                                xvid_regs_pkg::DATA,
                                xvid_regs_pkg::DATA_2: begin
                                    wdata_q <= reg_wr_i.data;
                                    req_sel <= 1'b1;
                                    req_wr  <= 1'b1;
                                end
                                xvid_regs_pkg::VID_MODE: begin
                                    video_ena_o <= video_ena_o ^ reg_wr_i.data[0];
                                end
                                default: ;                      // decoded, no effect
                            endcase
                        end
                    end
                    INIT: begin
                        video_ena_o <= 1'b0;
                        wr_addr     <= '0;
                        wdata_q     <= vram_pkg::CLEAR_DATA;
                        clr_count   <= vram_pkg::VRAM_AW'(vram_pkg::VRAM_WORDS - 1);
                        req_sel     <= 1'b1;
                        req_wr      <= 1'b1;
                        state       <= CLEAR;
                    end
                    CLEAR: begin
                        req_sel <= 1'b1;
                        req_wr  <= 1'b1;
                        if (clr_count != '0) begin
                            clr_count <= clr_count - 1'b1;
                        end else begin
                            // overrides the increment above
                            wr_addr <= vram_pkg::BANNER_ADDR;
                            wdata_q <= vram_pkg::BANNER[0];
                            ban_idx <= '0;
                            state   <= BANNER;
                        end
                    end
                    BANNER: begin
                        video_ena_o <= 1'b1;            // video comes up mid banner
                        if (ban_idx != vram_pkg::BANNER_IW'(vram_pkg::BANNER_LEN - 1)) begin
                            wdata_q <= vram_pkg::BANNER[ban_next];
                            ban_idx <= ban_next;
                            req_sel <= 1'b1;
                            req_wr  <= 1'b1;
                        end else begin
                            state <= IDLE;
                        end
                    end
                    default: state <= INIT;
                endcase
            end
        end
    end

    // write address for writes, read address otherwise
    always_comb begin
        blit_req_o.sel   = req_sel;
        blit_req_o.wr    = req_wr;
        blit_req_o.addr  = req_wr ? wr_addr : rd_addr;
        blit_req_o.wdata = wdata_q;
    end

    assign reg_busy_o    = (state != IDLE) | req_sel | rd_pend;
    assign reg_rd_data_o = rd_data_q;

endmodule

//--- vram_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port VRAM, time-sliced between video and blitter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vram_ram (
    input  logic                            clk,
    input  logic                            blit_cycle_i,
    input  vram_pkg::vram_req_t             blit_req_i,
    input  vram_pkg::vram_req_t             vid_req_i,
    output logic [vram_pkg::VRAM_DW-1:0]    rd_data_o
);

    logic [vram_pkg::VRAM_DW-1:0]   mem [vram_pkg::VRAM_WORDS];
    vram_pkg::vram_req_t            req;

    // slot owner gets the port
    assign req = blit_cycle_i ? blit_req_i : vid_req_i;

    always_ff @(posedge clk) begin
        if (req.sel && req.wr) begin
            mem[req.addr] <= req.wdata;
        end
        if (req.sel && !req.wr) begin
            rd_data_o <= mem[req.addr];     // one clock latency, shared by both readers
        end
    end

endmodule

//--- xvid_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Text video memory subsystem top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module xvid_top (
    input  logic                            clk,
    input  logic                            reset_i,
    input  xvid_regs_pkg::reg_wr_t          reg_wr_i,
    output logic                            reg_busy_o,
    output logic [vram_pkg::VRAM_DW-1:0]    reg_rd_data_o,
    output logic                            video_ena_o,
    output logic [vram_pkg::VRAM_DW-1:0]    video_word_o,
    output logic                            video_valid_o,
    output logic                            video_sof_o
);

    logic                           blit_cycle;
    vram_pkg::vram_req_t            blit_req;
    vram_pkg::vram_req_t            vid_req;
    logic [vram_pkg::VRAM_DW-1:0]   rd_data;       // one read bus for both clients

    video_scanner u_scanner (
        .clk           (clk),
        .reset_i       (reset_i),
        .video_ena_i   (video_ena_o),
        .blit_cycle_o  (blit_cycle),
        .vid_req_o     (vid_req),
        .rd_data_i     (rd_data),
        .video_word_o  (video_word_o),
        .video_valid_o (video_valid_o),
        .video_sof_o   (video_sof_o)
    );

    blitter u_blitter (
        .clk           (clk),
        .reset_i       (reset_i),
        .blit_cycle_i  (blit_cycle),
        .reg_wr_i      (reg_wr_i),
        .reg_busy_o    (reg_busy_o),
        .reg_rd_data_o (reg_rd_data_o),
        .video_ena_o   (video_ena_o),
        .blit_req_o    (blit_req),
        .rd_data_i     (rd_data)
    );

    vram_ram u_vram (
        .clk          (clk),
        .blit_cycle_i (blit_cycle),
        .blit_req_i   (blit_req),
        .vid_req_i    (vid_req),
        .rd_data_o    (rd_data)
    );

endmodule

//--- tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock (4 ns) and reset generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clk_o);
        reset_o <= 1'b0;    // released on the third rising edge
    end

endmodule

//--- xvid_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound checks on VRAM slot use, video qualifiers and register busy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module xvid_props (
    input logic                     clk,
    input logic                     reset_i,
    input logic                     blit_cycle_i,
    input vram_pkg::vram_req_t      blit_req_i,
    input xvid_regs_pkg::reg_wr_t   reg_wr_i,
    input logic                     reg_busy_i,
    input logic                     video_ena_i,
    input logic                     video_valid_i
);

    int unsigned    n_wr_held = 0;
    int unsigned    n_valid_ena = 0;
    int unsigned    n_valid_slot = 0;
    int unsigned    n_busy = 0;
    int unsigned    fail_count;
    logic           take;
    logic [2:0]     take_age;       // clocks since the last accepted strobe, 0 = none

    assign take       = reg_wr_i.strobe & ~reg_busy_i;
    assign fail_count = n_wr_held + n_valid_ena + n_valid_slot + n_busy;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            take_age <= '0;
        end else if (take) begin
            take_age <= 3'd1;
        end else if (take_age == 3'd4) begin
            take_age <= '0;
        end else if (take_age != '0) begin
            take_age <= take_age + 1'b1;
        end
    end

    // a blitter write waits unchanged for its blit slot
    blit_write_held: assert property (@(posedge clk) disable iff (reset_i)
        (blit_req_i.sel && blit_req_i.wr && !blit_cycle_i) |=>
        (blit_req_i.sel && blit_req_i.wr && $stable(blit_req_i.addr)
            && $stable(blit_req_i.wdata)))
        else begin
            $error("blitter write changed or dropped before its blit slot");
            n_wr_held++;
        end

    valid_needs_ena: assert property (@(posedge clk) disable iff (reset_i)
        !video_ena_i |-> !video_valid_i)
        else begin
            $error("video_valid_o high while video is off");
            n_valid_ena++;
        end

    valid_after_video_slot: assert property (@(posedge clk) disable iff (reset_i)
        video_valid_i |-> $past(!blit_cycle_i))
        else begin
            $error("video_valid_o not one clock after a video slot");
            n_valid_slot++;
        end

    busy_falls: assert property (@(posedge clk) disable iff (reset_i)
        (take_age == 3'd4) |-> !reg_busy_i)
        else begin
            $error("reg_busy_o still high 4 clocks after an accepted strobe");
            n_busy++;
        end

endmodule

//--- xvid_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the text video memory subsystem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module xvid_tb;

    localparam int BUSY_TIMEOUT  = 2000;                            // start-up clear is ~520
    localparam int FRAME_TIMEOUT = 2 * vram_pkg::VRAM_WORDS + 16;   // one frame of clocks
    localparam int BURST_LEN     = 12;

    logic                           clk;
    logic                           reset;
    xvid_regs_pkg::reg_wr_t         reg_wr;
    logic                           reg_busy;
    logic [vram_pkg::VRAM_DW-1:0]   reg_rd_data;
    logic                           video_ena;
    logic [vram_pkg::VRAM_DW-1:0]   video_word;
    logic                           video_valid;
    logic                           video_sof;

    logic [vram_pkg::VRAM_DW-1:0]   shadow [vram_pkg::VRAM_WORDS];  // expected VRAM
    int                             written [$];
    int                             mismatches = 0;
    int                             timeouts = 0;
    int                             prop_fails;

    tb_clock_gen u_clk_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    xvid_top UUT (
        .clk           (clk),
        .reset_i       (reset),
        .reg_wr_i      (reg_wr),
        .reg_busy_o    (reg_busy),
        .reg_rd_data_o (reg_rd_data),
        .video_ena_o   (video_ena),
        .video_word_o  (video_word),
        .video_valid_o (video_valid),
        .video_sof_o   (video_sof)
    );

    bind xvid_top xvid_props u_props (
        .clk           (clk),
        .reset_i       (reset_i),
        .blit_cycle_i  (blit_cycle),
        .blit_req_i    (blit_req),
        .reg_wr_i      (reg_wr_i),
        .reg_busy_i    (reg_busy_o),
        .video_ena_i   (video_ena_o),
        .video_valid_i (video_valid_o)
    );

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (reg_busy && n < BUSY_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (reg_busy) begin
            $display("timeout at %0t: reg_busy_o stayed high while waiting for %s", $time, what);
            timeouts++;
        end
    endtask

    // one-cycle strobe once the blitter is free
    task automatic reg_write(input xvid_regs_pkg::xvid_reg_t num, input logic [15:0] data);
        wait_idle(num.name());
        @(posedge clk);
        reg_wr.strobe <= 1'b1;
        reg_wr.num    <= num;
        reg_wr.data   <= data;
        @(posedge clk);
        reg_wr.strobe <= 1'b0;
    endtask

    task automatic write_burst(input int base, input int count);
        int                         k;
        int                         a;
        logic [15:0]                d;
        xvid_regs_pkg::xvid_reg_t   num;
        reg_write(xvid_regs_pkg::WR_ADDR, 16'(base));
        for (k = 0; k < count; k++) begin
            a   = (base + k) % vram_pkg::VRAM_WORDS;   // auto increment wraps
            d   = 16'($urandom);
            num = ($urandom % 3 == 0) ? xvid_regs_pkg::DATA_2 : xvid_regs_pkg::DATA;
            reg_write(num, d);
            shadow[a] = d;
            written.push_back(a);
        end
    endtask

    task automatic read_check(input int addr);
        reg_write(xvid_regs_pkg::RD_ADDR, 16'(addr));
        wait_idle("read data");
        assert (reg_rd_data == shadow[addr]) else begin
            $display("ERR %0t: read of address %0d gave %h, expected %h",
                     $time, addr, reg_rd_data, shadow[addr]);
            mismatches++;
        end
    endtask

    // wait for start of frame, then compare one whole frame against the shadow
    task automatic check_frame(input string what);
        int n;
        int idx;
        n = 0;
        @(negedge clk);
        while (!video_sof && n < FRAME_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!video_sof) begin
            $display("timeout at %0t: no start of frame for the %s frame", $time, what);
            timeouts++;
            return;
        end
        idx = 0;
        n   = 0;
        while (idx < vram_pkg::VRAM_WORDS && n < FRAME_TIMEOUT) begin
            if (video_valid) begin
                assert (video_word == shadow[idx] && video_sof == (idx == 0)) else begin
                    $display("ERR %0t: %s frame address %0d is %h sof %b, expected %h",
                             $time, what, idx, video_word, video_sof, shadow[idx]);
                    mismatches++;
                end
                idx++;
            end
            if (idx < vram_pkg::VRAM_WORDS) begin
                @(negedge clk);
                n++;
            end
        end
        if (idx < vram_pkg::VRAM_WORDS) begin
            $display("timeout at %0t: %s frame stopped after %0d words", $time, what, idx);
            timeouts++;
        end
    endtask

    task automatic check_video_quiet(input int clocks);
        int n;
        for (n = 0; n < clocks; n++) begin
            @(negedge clk);
            assert (!video_valid) else begin
                $display("ERR %0t: video_valid_o high with video off", $time);
                mismatches++;
            end
        end
    endtask

    initial begin
        int n;
        int k;
        void'($urandom(94472));
        reg_wr = '0;
        for (k = 0; k < vram_pkg::VRAM_WORDS; k++) begin
            shadow[k] = vram_pkg::CLEAR_DATA;
        end
        for (k = 0; k < vram_pkg::BANNER_LEN; k++) begin
            shadow[int'(vram_pkg::BANNER_ADDR) + k] = vram_pkg::BANNER[k];
        end

        // start-up clear and banner
        n = 0;
        @(negedge clk);
        while (!video_ena && n < BUSY_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!video_ena) begin
            $display("timeout at %0t: video_ena_o never rose after reset", $time);
            timeouts++;
        end
        wait_idle("start-up");
        check_frame("start-up");

        // auto increment, second burst wraps past the top
        write_burst(int'($urandom % vram_pkg::VRAM_WORDS), BURST_LEN);
        write_burst(vram_pkg::VRAM_WORDS - 1 - int'($urandom % 4), BURST_LEN);
        check_frame("burst");
        foreach (written[i]) begin
            read_check(written[i]);
        end

        // video off, on, then a write with bit 0 clear
        reg_write(xvid_regs_pkg::VID_MODE, 16'h0001);
        @(negedge clk);
        assert (!video_ena) else begin
            $display("ERR %0t: video_ena_o still high after toggle", $time);
            mismatches++;
        end
        check_video_quiet(vram_pkg::VRAM_WORDS + 16);
        reg_write(xvid_regs_pkg::VID_MODE, 16'h0001);
        check_frame("video on");
        reg_write(xvid_regs_pkg::VID_MODE, 16'hFFFE);
        wait_idle("mode write");
        assert (video_ena) else begin
            $display("ERR %0t: VID_MODE with bit 0 clear turned video off", $time);
            mismatches++;
        end

        // unused register numbers leave VRAM alone
        for (k = 0; k < 8; k++) begin
            reg_write(xvid_regs_pkg::xvid_reg_t'(5 + $urandom % 11), 16'($urandom));
        end
        check_frame("ignored registers");

        repeat (4) @(negedge clk);
        prop_fails = int'(UUT.u_props.fail_count);
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, prop_fails);
        if (mismatches == 0 && timeouts == 0 && prop_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
vram_pkg.sv
xvid_regs_pkg.sv
video_scanner.sv
blitter.sv
vram_ram.sv
xvid_top.sv
tb_clock_gen.sv
xvid_props.sv
xvid_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := xvid_tb
FILELIST  := all.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
RUNFLAGS  := +verilator+error+limit+100
OBJDIR    := obj_dir
PASS_MSG  := TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUNFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
